// ==== Makefile ====
# Verilator build and run of the traced core testbench

TOP := tb_core_top_tracing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, result taken from sim.log"
	@echo "  clean  remove the build directory and the log"

obj_dir/V$(TOP): all.f $(wildcard src/*.sv src/*.svh bench/*.sv)
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "All tests passed!" sim.log; then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
+incdir+src
src/core_trace_pkg.sv
src/mini_core.sv
src/trace_timestamp.sv
src/trace_ctrl_fsm.sv
src/trace_buffer.sv
src/core_top_tracing.sv
bench/tb_core_top_tracing.sv

// ==== bench/tb_core_top_tracing.sv ====
/* Testbench for the traced core with clock, reset, random stimulus,
   reference model, trace FIFO drain and field checks */

`timescale 1ns/10ps
`default_nettype none
`include "trace_params.svh"

module tb_core_top_tracing;

  localparam int          timeout_cycles = 50;
  localparam logic [31:0] boot_addr      = 32'h0000_1000;

  logic                         clk_i = 1'b0;
  logic                         rst_i;
  logic [31:0]                  instr_i;
  logic                         instr_valid_i;
  logic                         trace_start_i;
  logic                         trace_stop_i;
  logic                         trace_rd_i;
  core_trace_pkg::trace_entry_t trace_entry_o;
  logic                         trace_empty_o;
  logic                         trace_overflow_o;
  core_trace_pkg::trc_state_e   trace_state_o;

  // Reference model state
  logic [31:0] model_rf [`NUM_REGS];
  logic [31:0] model_pc;
  int          issued_cnt;
  int          cycle_cnt = 0;
  logic        capturing;

  core_trace_pkg::trace_entry_t exp_q [$];
  int                           exp_cyc_q [$];

  int checks;
  int mismatches;
  int other_errors;

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  core_top_tracing dut (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .boot_addr_i     (boot_addr),
    .instr_i         (instr_i),
    .instr_valid_i   (instr_valid_i),
    .trace_start_i   (trace_start_i),
    .trace_stop_i    (trace_stop_i),
    .trace_rd_i      (trace_rd_i),
    .trace_entry_o   (trace_entry_o),
    .trace_empty_o   (trace_empty_o),
    .trace_overflow_o(trace_overflow_o),
    .trace_state_o   (trace_state_o)
  );

  // Computes the expected entry and advances the model
  function automatic core_trace_pkg::trace_entry_t ref_retire(input logic [31:0] insn);
    core_trace_pkg::trace_entry_t e;
    logic [2:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        writes;
    rd     = insn[6:4];
    a      = (insn[9:7] == 3'd0) ? 32'h0 : model_rf[insn[9:7]];
    b      = (insn[12:10] == 3'd0) ? 32'h0 : model_rf[insn[12:10]];
    res    = 32'h0;
    writes = 1'b1;
    e      = '0;
    case (insn[3:0])
      core_trace_pkg::NOP: writes = 1'b0;
      core_trace_pkg::ADD: res = a + b;
      core_trace_pkg::SUB: res = a - b;
      core_trace_pkg::AND: res = a & b;
      core_trace_pkg::OR:  res = a | b;
      core_trace_pkg::XOR: res = a ^ b;
      core_trace_pkg::LI:  res = {16'h0000, insn[31:16]};
      default: begin
        writes = 1'b0;
        e.trap = 1'b1;
      end
    endcase
    e.order    = issued_cnt[7:0];
    e.pc       = model_pc;
    e.insn     = insn;
    e.rd_addr  = writes ? rd : 3'd0;
    e.rd_wdata = (writes && rd != 3'd0) ? res : 32'h0;
    if (writes && rd != 3'd0) begin
      model_rf[rd] = res;
    end
    model_pc   = model_pc + 32'd4;
    issued_cnt = issued_cnt + 1;
    return e;
  endfunction

  function automatic logic [31:0] make_insn(input logic [3:0] op, input logic [2:0] rd,
                                            input logic [2:0] rs1, input logic [2:0] rs2,
                                            input logic [15:0] imm);
    return {imm, 3'b000, rs2, rs1, rd, op};
  endfunction

  // Roughly a fifth of the opcodes are illegal
  function automatic logic [31:0] rand_insn();
    logic [31:0] r;
    logic [31:0] pick;
    logic [3:0]  op;
    r    = $urandom;
    pick = $urandom % 32'd9;
    if (pick < 32'd7) begin
      op = pick[3:0];
    end else begin
      op = 4'd7 + 4'($urandom % 32'd9);
    end
    return {r[31:4], op};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic issue(input logic [31:0] insn);
    @(posedge clk_i);
    instr_i       <= insn;
    instr_valid_i <= 1'b1;
    if (capturing && exp_q.size() < `TRACE_DEPTH) begin
      exp_q.push_back(ref_retire(insn));
      exp_cyc_q.push_back(cycle_cnt);
    end else begin
      void'(ref_retire(insn));
    end
  endtask

  // Leaves time for the last retirement to reach the FIFO
  task automatic end_burst();
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic run_burst(input int n);
    for (int i = 0; i < n; i++) begin
      issue(rand_insn());
      if (($urandom % 32'd3) == 32'd0 && i != n - 1) begin
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
      end
    end
    end_burst();
  endtask

  task automatic wait_state(input core_trace_pkg::trc_state_e s);
    int t;
    t = 0;
    @(negedge clk_i);
    while (trace_state_o != s && t < timeout_cycles) begin
      @(negedge clk_i);
      t++;
    end
    if (trace_state_o != s) begin
      other_errors++;
      $display("Timed out waiting for the trace FSM to reach state %s", s.name());
    end
  endtask

  task automatic start_trace();
    @(posedge clk_i);
    trace_start_i <= 1'b1;
    @(posedge clk_i);
    trace_start_i <= 1'b0;
    exp_q.delete();
    exp_cyc_q.delete();
    capturing = 1'b1;
    wait_state(core_trace_pkg::CAPTURE);
  endtask

  task automatic stop_trace();
    @(posedge clk_i);
    trace_stop_i <= 1'b1;
    @(posedge clk_i);
    trace_stop_i <= 1'b0;
    capturing = 1'b0;
    wait_state(core_trace_pkg::STOPPED);
  endtask

  // Pops every expected entry and compares it field by field
  task automatic drain_check();
    core_trace_pkg::trace_entry_t e;
    logic [`TS_WIDTH-1:0]         prev_ts;
    logic [`TS_WIDTH-1:0]         first_ts;
    int                           cyc;
    int                           prev_cyc;
    int                           first_cyc;
    int                           t;
    bit                           have_prev;
    have_prev = 1'b0;
    prev_ts   = '0;
    first_ts  = '0;
    prev_cyc  = 0;
    first_cyc = 0;
    while (exp_q.size() > 0) begin
      e   = exp_q.pop_front();
      cyc = exp_cyc_q.pop_front();
      t   = 0;
      @(negedge clk_i);
      while (trace_empty_o && t < timeout_cycles) begin
        @(negedge clk_i);
        t++;
      end
      if (trace_empty_o) begin
        other_errors++;
        $display("Timed out waiting for the trace entry with order %0d", e.order);
        exp_q.delete();
        exp_cyc_q.delete();
        return;
      end
      check_val("trace_entry_o.order", 32'(trace_entry_o.order), 32'(e.order));
      check_val("trace_entry_o.pc", trace_entry_o.pc, e.pc);
      check_val("trace_entry_o.insn", trace_entry_o.insn, e.insn);
      check_val("trace_entry_o.trap", 32'(trace_entry_o.trap), 32'(e.trap));
      check_val("trace_entry_o.rd_addr", 32'(trace_entry_o.rd_addr), 32'(e.rd_addr));
      check_val("trace_entry_o.rd_wdata", trace_entry_o.rd_wdata, e.rd_wdata);
      if (have_prev) begin
        checks++;
        if (trace_entry_o.timestamp < prev_ts ||
            int'(trace_entry_o.timestamp - prev_ts) > (cyc - prev_cyc) / `TS_PRESCALE + 1) begin
          mismatches++;
          $display("MISMATCH trace_entry_o.timestamp: got %h after %h, %0d cycles apart",
                   trace_entry_o.timestamp, prev_ts, cyc - prev_cyc);
        end
        // At least one tick per full prescale period since the burst began
        checks++;
        if (int'(trace_entry_o.timestamp - first_ts) < (cyc - first_cyc) / `TS_PRESCALE) begin
          mismatches++;
          $display("MISMATCH trace_entry_o.timestamp: got %h, first %h, %0d cycles apart",
                   trace_entry_o.timestamp, first_ts, cyc - first_cyc);
        end
      end else begin
        first_ts  = trace_entry_o.timestamp;
        first_cyc = cyc;
      end
      prev_ts   = trace_entry_o.timestamp;
      prev_cyc  = cyc;
      have_prev = 1'b1;
      @(posedge clk_i);
      trace_rd_i <= 1'b1;
      @(posedge clk_i);
      trace_rd_i <= 1'b0;
    end
    @(negedge clk_i);
    check_val("trace_empty_o", 32'(trace_empty_o), 32'd1);
  endtask

  initial begin
    void'($urandom(41));
    rst_i         <= 1'b1;
    instr_i       <= 32'h0;
    instr_valid_i <= 1'b0;
    trace_start_i <= 1'b0;
    trace_stop_i  <= 1'b0;
    trace_rd_i    <= 1'b0;
    for (int i = 0; i < `NUM_REGS; i++) begin
      model_rf[i] = 32'h0;
    end
    model_pc     = boot_addr;
    issued_cnt   = 0;
    capturing    = 1'b0;
    checks       = 0;
    mismatches   = 0;
    other_errors = 0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);

    check_val("trace_state_o", 32'(trace_state_o), 32'(core_trace_pkg::IDLE));
    check_val("trace_empty_o", 32'(trace_empty_o), 32'd1);
    check_val("trace_overflow_o", 32'(trace_overflow_o), 32'd0);

    // Retirements while idle count for order but are not captured
    run_burst(5);
    check_val("trace_empty_o", 32'(trace_empty_o), 32'd1);

    // r0 write and read back and an illegal opcode before random ones
    start_trace();
    issue(make_insn(core_trace_pkg::LI, 3'd0, 3'd0, 3'd0, 16'hbeef));
    issue(make_insn(core_trace_pkg::OR, 3'd2, 3'd0, 3'd0, 16'h0000));
    issue(make_insn(4'hf, 3'd3, 3'd1, 3'd1, 16'h1234));
    run_burst(`TRACE_DEPTH - 4);
    drain_check();

    stop_trace();
    run_burst(4);
    check_val("trace_empty_o", 32'(trace_empty_o), 32'd1);

    // Overflow keeps the oldest entries
    start_trace();
    run_burst(`TRACE_DEPTH + 3);
    check_val("trace_overflow_o", 32'(trace_overflow_o), 32'd1);
    drain_check();

    // Restart with entries pending clears both flag and FIFO
    run_burst(3);
    check_val("trace_overflow_o", 32'(trace_overflow_o), 32'd1);
    check_val("trace_empty_o", 32'(trace_empty_o), 32'd0);
    start_trace();
    check_val("trace_overflow_o", 32'(trace_overflow_o), 32'd0);
    check_val("trace_empty_o", 32'(trace_empty_o), 32'd1);

    $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/core_top_tracing.sv ====
/* Top level: mini core plus tracer (timestamp, capture FSM,
   trace FIFO) joined by the retirement record */

`timescale 1ns/10ps
`default_nettype none
`include "trace_params.svh"

module core_top_tracing (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic [31:0]                  boot_addr_i,
  input  logic [31:0]                  instr_i,
  input  logic                         instr_valid_i,
  input  logic                         trace_start_i,
  input  logic                         trace_stop_i,
  input  logic                         trace_rd_i,
  output core_trace_pkg::trace_entry_t trace_entry_o,
  output logic                         trace_empty_o,
  output logic                         trace_overflow_o,
  output core_trace_pkg::trc_state_e   trace_state_o
);

  core_trace_pkg::retire_t      rvfi_retire;
  core_trace_pkg::trace_entry_t trace_entry;

  logic [7:0]           order;
  logic [`TS_WIDTH-1:0] timestamp;
  logic                 buf_push;
  logic                 buf_flush;
  logic                 buf_full;

  mini_core u_core (
    .clk_i,
    .rst_i,
    .boot_addr_i,
    .instr_i,
    .instr_valid_i,
    .retire_o      (rvfi_retire)
  );

  trace_timestamp u_ts (
    .clk_i,
    .rst_i,
    .retire_valid_i(rvfi_retire.valid),
    .order_o       (order),
    .timestamp_o   (timestamp)
  );

  // Order is the pre-increment value of the retiring cycle
  assign trace_entry = '{
    order:     order,
    timestamp: timestamp,
    trap:      rvfi_retire.trap,
    pc:        rvfi_retire.pc,
    insn:      rvfi_retire.insn,
    rd_addr:   rvfi_retire.rd_addr,
    rd_wdata:  rvfi_retire.rd_wdata
  };

  trace_ctrl_fsm u_ctrl (
    .clk_i,
    .rst_i,
    .start_i       (trace_start_i),
    .stop_i        (trace_stop_i),
    .retire_valid_i(rvfi_retire.valid),
    .buf_full_i    (buf_full),
    .push_o        (buf_push),
    .flush_o       (buf_flush),
    .overflow_o    (trace_overflow_o),
    .state_o       (trace_state_o)
  );

  trace_buffer u_buf (
    .clk_i,
    .rst_i,
    .flush_i(buf_flush),
    .push_i (buf_push),
    .entry_i(trace_entry),
    .pop_i  (trace_rd_i),
    .entry_o(trace_entry_o),
    .empty_o(trace_empty_o),
    .full_o (buf_full)
  );

endmodule

`default_nettype wire

// ==== src/core_trace_pkg.sv ====
/* Shared types: opcode and trace state enums,
   retirement record and trace entry structs */

`default_nettype none
`include "trace_params.svh"

package core_trace_pkg;

  // Opcode in instruction bits 3:0, any other code traps
  typedef enum logic [3:0] {
    NOP = 4'h0,
    ADD = 4'h1,
    SUB = 4'h2,
    AND = 4'h3,
    OR  = 4'h4,
    XOR = 4'h5,
    LI  = 4'h6
  } op_e;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    CAPTURE = 2'd1,
    STOPPED = 2'd2
  } trc_state_e;

  // One retired instruction, in the manner of an RVFI bundle
  typedef struct packed {
    logic                         valid;
    logic                         trap;
    logic [31:0]                  pc;
    logic [31:0]                  insn;
    logic [$clog2(`NUM_REGS)-1:0] rd_addr;
    logic [31:0]                  rd_wdata;
  } retire_t;

  // Captured trace record as stored in the FIFO
  typedef struct packed {
    logic [7:0]                   order;
    logic [`TS_WIDTH-1:0]         timestamp;
    logic                         trap;
    logic [31:0]                  pc;
    logic [31:0]                  insn;
    logic [$clog2(`NUM_REGS)-1:0] rd_addr;
    logic [31:0]                  rd_wdata;
  } trace_entry_t;

endpackage

`default_nettype wire

// ==== src/mini_core.sv ====
/* Minimal core: decode, register file, ALU and pc,
   one registered retirement record per instruction */

`timescale 1ns/10ps
`default_nettype none
`include "trace_params.svh"

module mini_core (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [31:0]             boot_addr_i,
  input  logic [31:0]             instr_i,
  input  logic                    instr_valid_i,
  output core_trace_pkg::retire_t retire_o
);

  localparam int reg_aw = $clog2(`NUM_REGS);

  core_trace_pkg::op_e     op;
  core_trace_pkg::retire_t retire_d;
  core_trace_pkg::retire_t retire_q;

  logic [reg_aw-1:0] rd;
  logic [reg_aw-1:0] rs1;
  logic [reg_aw-1:0] rs2;
  logic [31:0]       imm;
  logic [31:0]       rs1_data;
  logic [31:0]       rs2_data;
  logic [31:0]       result;
  logic              writes_rd;
  logic              trap;
  logic              rd_nz_write;
  logic [31:0]       rf [`NUM_REGS];
  logic [31:0]       pc_q;

  // Instruction fields
  assign op  = core_trace_pkg::op_e'(instr_i[3:0]);
  assign rd  = instr_i[6:4];
  assign rs1 = instr_i[9:7];
  assign rs2 = instr_i[12:10];
  assign imm = {16'h0000, instr_i[31:16]};

  // r0 reads as zero
  assign rs1_data = (rs1 == '0) ? 32'h0 : rf[rs1];
  assign rs2_data = (rs2 == '0) ? 32'h0 : rf[rs2];

  always_comb begin
    result    = 32'h0;
    writes_rd = 1'b1;
    trap      = 1'b0;
    case (op)
      core_trace_pkg::NOP: writes_rd = 1'b0;
      core_trace_pkg::ADD: result = rs1_data + rs2_data;
      core_trace_pkg::SUB: result = rs1_data - rs2_data;
      core_trace_pkg::AND: result = rs1_data & rs2_data;
      core_trace_pkg::OR:  result = rs1_data | rs2_data;
      core_trace_pkg::XOR: result = rs1_data ^ rs2_data;
      core_trace_pkg::LI:  result = imm;
      default: begin
        writes_rd = 1'b0;
        trap      = 1'b1;
      end
    endcase
  end

  assign rd_nz_write = writes_rd && (rd != '0);

  // rd_addr follows the instruction, wdata is zero for r0 as in RVFI
  always_comb begin
    retire_d.valid    = 1'b1;
    retire_d.trap     = trap;
    retire_d.pc       = pc_q;
    retire_d.insn     = instr_i;
    retire_d.rd_addr  = writes_rd ? rd : '0;
    retire_d.rd_wdata = rd_nz_write ? result : 32'h0;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        rf[i] <= 32'h0;
      end
    end else if (instr_valid_i && rd_nz_write) begin
      rf[rd] <= result;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= boot_addr_i;
    end else if (instr_valid_i) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // Payload only loads with a new instruction
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      retire_q.valid <= 1'b0;
    end else if (instr_valid_i) begin
      retire_q <= retire_d;
    end else begin
      retire_q.valid <= 1'b0;
    end
  end

  assign retire_o = retire_q;

  a_retire_after_instr: assert property (
    @(posedge clk_i) disable iff (rst_i) retire_o.valid |-> $past(instr_valid_i)
  ) else $error("retire valid without an instruction in the previous cycle");

endmodule

`default_nettype wire

// ==== src/trace_buffer.sv ====
/* First-word-fall-through FIFO of trace entries
   with single-cycle flush */

`timescale 1ns/10ps
`default_nettype none
`include "trace_params.svh"

module trace_buffer (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         flush_i,
  input  logic                         push_i,
  input  core_trace_pkg::trace_entry_t entry_i,
  input  logic                         pop_i,
  output core_trace_pkg::trace_entry_t entry_o,
  output logic                         empty_o,
  output logic                         full_o
);

  localparam int ptr_w = (`TRACE_DEPTH > 1) ? $clog2(`TRACE_DEPTH) : 1;
  localparam int cnt_w = $clog2(`TRACE_DEPTH + 1);

  core_trace_pkg::trace_entry_t mem [`TRACE_DEPTH];

  logic [ptr_w-1:0] rptr_q;
  logic [ptr_w-1:0] wptr_q;
  logic [cnt_w-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(`TRACE_DEPTH - 1)) ? '0 : p + ptr_w'(1);
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == cnt_w'(`TRACE_DEPTH));
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Oldest entry always visible at the head
  assign entry_o = mem[rptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wptr_q] <= entry_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      rptr_q  <= '0;
      wptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (do_pop) begin
        rptr_q <= ptr_inc(rptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + cnt_w'(1);
        2'b01:   count_q <= count_q - cnt_w'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  a_count_bound: assert property (
    @(posedge clk_i) disable iff (rst_i) count_q <= cnt_w'(`TRACE_DEPTH)
  ) else $error("trace buffer occupancy above depth");

endmodule

`default_nettype wire

// ==== src/trace_ctrl_fsm.sv ====
/* Trace capture FSM: start/stop control, push or drop
   decision per retirement, sticky overflow flag */

`timescale 1ns/10ps
`default_nettype none

module trace_ctrl_fsm (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       start_i,
  input  logic                       stop_i,
  input  logic                       retire_valid_i,
  input  logic                       buf_full_i,
  output logic                       push_o,
  output logic                       flush_o,
  output logic                       overflow_o,
  output core_trace_pkg::trc_state_e state_o
);

  core_trace_pkg::trc_state_e state_q;
  core_trace_pkg::trc_state_e state_d;

  logic capture_hit;
  logic drop;
  logic overflow_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      core_trace_pkg::IDLE,
      core_trace_pkg::STOPPED: begin
        if (start_i) begin
          state_d = core_trace_pkg::CAPTURE;
        end
      end
      core_trace_pkg::CAPTURE: begin
        if (stop_i && !start_i) begin
          state_d = core_trace_pkg::STOPPED;
        end
      end
      default: state_d = core_trace_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= core_trace_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // A retirement that coincides with a restart belongs to the old run
  assign capture_hit = (state_q == core_trace_pkg::CAPTURE) && retire_valid_i && !start_i;
  assign push_o      = capture_hit && !buf_full_i;
  assign drop        = capture_hit && buf_full_i;
  assign flush_o     = start_i;

  always_ff @(posedge clk_i) begin
    if (rst_i || start_i) begin
      overflow_q <= 1'b0;
    end else if (drop) begin
      overflow_q <= 1'b1;
    end
  end

  assign overflow_o = overflow_q;
  assign state_o    = state_q;

  a_no_push_when_full: assert property (
    @(posedge clk_i) disable iff (rst_i) push_o |-> !buf_full_i
  ) else $error("push into a full trace buffer");

  a_state_legal: assert property (
    @(posedge clk_i) disable iff (rst_i)
    state_q inside {core_trace_pkg::IDLE, core_trace_pkg::CAPTURE, core_trace_pkg::STOPPED}
  ) else $error("trace FSM in illegal state");

endmodule

`default_nettype wire

// ==== src/trace_params.svh ====
/* Sizing macros for the core register file, the trace FIFO
   and the trace timestamp */

`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

// Core register file
`define NUM_REGS 8

// Trace FIFO entries
`define TRACE_DEPTH 8

// Timestamp counter width in bits
`define TS_WIDTH 16

// Clock cycles per timestamp tick
`define TS_PRESCALE 4

`endif

// ==== src/trace_timestamp.sv ====
/* Prescaled trace timestamp and retirement order counter */

`timescale 1ns/10ps
`default_nettype none
`include "trace_params.svh"

module trace_timestamp (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 retire_valid_i,
  output logic [7:0]           order_o,
  output logic [`TS_WIDTH-1:0] timestamp_o
);

  localparam int presc_w = (`TS_PRESCALE > 1) ? $clog2(`TS_PRESCALE) : 1;

  logic [presc_w-1:0]   presc_q;
  logic                 tick;
  logic [7:0]           order_q;
  logic [`TS_WIDTH-1:0] ts_q;

  assign tick = (presc_q == presc_w'(`TS_PRESCALE - 1));

  always_ff @(posedge clk_i) begin
    if (rst_i || tick) begin
      presc_q <= '0;
    end else begin
      presc_q <= presc_q + presc_w'(1);
    end
  end

  // Wraps at TS_WIDTH bits
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ts_q <= '0;
    end else if (tick) begin
      ts_q <= ts_q + `TS_WIDTH'(1);
    end
  end

  // Counts every retirement, captured or not
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      order_q <= 8'd0;
    end else if (retire_valid_i) begin
      order_q <= order_q + 8'd1;
    end
  end

  assign order_o     = order_q;
  assign timestamp_o = ts_q;

endmodule

`default_nettype wire
